/* aluPkg.sv */
package aluPkg;

  //////////////////////////////////////////////////
  // Widths and register map
  //////////////////////////////////////////////////
  localparam int dataWidth = 16;                         // Operand and result width
  localparam int addrWidth = 4;                          // AXI byte address width

  localparam logic [addrWidth-1:0] regOpA    = 4'h0;   // Operand A
  localparam logic [addrWidth-1:0] regOpB    = 4'h4;   // Operand B
  localparam logic [addrWidth-1:0] regCtrl   = 4'h8;   // Opcode, write starts an operation
  localparam logic [addrWidth-1:0] regResult = 4'hC;   // Result and flags, read only

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  //////////////////////////////////////////////////
  // ALU opcodes and core request/response
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    opAdd    = 3'd0,   // Saturating add
    opSub    = 3'd1,   // Saturating subtract
    opXor    = 3'd2,
    opPaddsb = 3'd3,   // Four saturating nibble adds
    opSll    = 3'd4,
    opSra    = 3'd5,
    opRor    = 3'd6
  } aluOpE;

  typedef struct packed {
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    aluOpE                op;
  } aluReqT;

  typedef struct packed {
    logic z;   // Zero
    logic v;   // Signed overflow
    logic n;   // Negative
  } aluFlagsT;

  typedef struct packed {
    logic [dataWidth-1:0] result;
    aluFlagsT             flags;
    aluFlagsT             flagMask;   // A set bit means the flag gets written
  } aluRspT;

  //////////////////////////////////////////////////
  // AXI4-Lite channels
  //////////////////////////////////////////////////
  typedef struct packed {
    logic                 awvalid;
    logic [addrWidth-1:0] awaddr;
    logic                 wvalid;
    logic [31:0]          wdata;
    logic [3:0]           wstrb;    // Not used, registers are written whole
    logic                 bready;
    logic                 arvalid;
    logic [addrWidth-1:0] araddr;
    logic                 rready;
  } axiLiteReqT;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axiLiteRspT;

endpackage

/* claAdder4.sv */
`timescale 1ns/10ps

module claAdder4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       pGroup,    // Whole nibble propagates
  output logic       gGroup,    // Nibble generates a carry by itself
  output logic       posOvfl,
  output logic       negOvfl
);

  logic [3:0] p;   // Per-bit propagate
  logic [3:0] g;   // Per-bit generate
  logic [3:0] c;   // Carry into each bit

  assign p = a ^ b;
  assign g = a & b;

  // Lookahead carries, all from cin and the p/g terms
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

  // Group terms for the second lookahead level
  assign pGroup = &p;
  assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                | (p[3] & p[2] & p[1] & g[0]);

  // Signed nibble overflow, left to the caller to saturate
  assign posOvfl = ~a[3] & ~b[3] & sum[3];   // Two positives gave a negative
  assign negOvfl = a[3] & b[3] & ~sum[3];    // Two negatives gave a positive

endmodule

/* claAdder16.sv */
`timescale 1ns/10ps

module claAdder16 (
  input  logic [aluPkg::dataWidth-1:0] a,
  input  logic [aluPkg::dataWidth-1:0] b,
  input  logic                         sub,
  output logic [aluPkg::dataWidth-1:0] sum,
  output logic                         ovfl,
  output logic                         posOvfl,
  output logic                         negOvfl
);

  import aluPkg::*;

  logic [dataWidth-1:0] bOp;      // B or its complement
  logic [dataWidth-1:0] sumRaw;   // Sum before saturation
  logic [3:0]           pGrp;     // Group propagate per nibble
  logic [3:0]           gGrp;     // Group generate per nibble
  logic [3:0]           carry;    // Carry into each nibble

  assign bOp = sub ? ~b : b;   // Two's complement with carry-in of one

  //////////////////////////////////////////////////
  // Second-level carry chain
  //////////////////////////////////////////////////
  assign carry[0] = sub;
  assign carry[1] = gGrp[0] | (pGrp[0] & sub);
  assign carry[2] = gGrp[1] | (pGrp[1] & gGrp[0]) | (pGrp[1] & pGrp[0] & sub);
  assign carry[3] = gGrp[2] | (pGrp[2] & gGrp[1]) | (pGrp[2] & pGrp[1] & gGrp[0])
                  | (pGrp[2] & pGrp[1] & pGrp[0] & sub);

  // Four nibble blocks, overflow taken from the full word below
  for (genvar i = 0; i < 4; i++) begin : gNib
    claAdder4 uCla (
      .a      (a[4*i +: 4]),
      .b      (bOp[4*i +: 4]),
      .cin    (carry[i]),
      .sum    (sumRaw[4*i +: 4]),
      .pGroup (pGrp[i]),
      .gGroup (gGrp[i]),
      .posOvfl(),
      .negOvfl()
    );
  end

  //////////////////////////////////////////////////
  // Signed overflow and saturation
  //////////////////////////////////////////////////
  assign posOvfl = ~a[dataWidth-1] & ~bOp[dataWidth-1] & sumRaw[dataWidth-1];
  assign negOvfl = a[dataWidth-1] & bOp[dataWidth-1] & ~sumRaw[dataWidth-1];
  assign ovfl    = posOvfl | negOvfl;

  assign sum = posOvfl ? 16'h7FFF :   // Clamp to largest positive
               negOvfl ? 16'h8000 :   // Clamp to most negative
               sumRaw;

  // Sign rule must match the carries into and out of the top bit
  always_comb begin : chkOvfl
    assert #0 (!(posOvfl && negOvfl)
               && ovfl == ((gGrp[3] | (pGrp[3] & carry[3]))
                           ^ sumRaw[dataWidth-1] ^ a[dataWidth-1] ^ bOp[dataWidth-1]))
      else $error("claAdder16 overflow disagrees with the top-bit carries");
  end

endmodule

/* aluShifter.sv */
`timescale 1ns/10ps

module aluShifter (
  input  logic [aluPkg::dataWidth-1:0] data,
  input  logic [3:0]                   amount,   // Shift or rotate count 0..15
  input  aluPkg::aluOpE                op,
  output logic [aluPkg::dataWidth-1:0] shifted
);

  import aluPkg::*;

  logic [dataWidth-1:0] stg [5];   // Stage 0 is the input

  assign stg[0] = data;

  //////////////////////////////////////////////////
  // Log shifter, stage k moves by 2**k
  //////////////////////////////////////////////////
  for (genvar k = 0; k < 4; k++) begin : gStage
    logic [dataWidth-1:0] cur;
    logic [dataWidth-1:0] left;    // Zero filled from the right
    logic [dataWidth-1:0] right;   // Zero filled from the left
    logic [dataWidth-1:0] fill;    // Bits entering at the top on a right move

    assign cur   = stg[k];
    assign left  = cur << (2**k);
    assign right = cur >> (2**k);

    always_comb begin
      case (op)
        opSra:   fill = {dataWidth{cur[dataWidth-1]}} << (dataWidth - 2**k);   // Sign copies
        opRor:   fill = cur << (dataWidth - 2**k);   // Low bits wrap to the top
        default: fill = '0;
      endcase
    end

    // Stage is bypassed when its amount bit is clear
    assign stg[k+1] = !amount[k]   ? cur  :
                      (op == opSll) ? left :
                      (right | fill);
  end

  assign shifted = stg[4];

endmodule

/* aluCore.sv */
`timescale 1ns/10ps

module aluCore (
  input  aluPkg::aluReqT aluReq,
  output aluPkg::aluRspT aluRsp
);

  import aluPkg::*;

  logic                 isSub;
  logic                 isArith;     // ADD or SUB, updates every flag
  logic [dataWidth-1:0] addSum;      // Saturated 16-bit sum
  logic                 addOvfl;
  logic [dataWidth-1:0] nibSum;      // Raw PADDSB sums
  logic [3:0]           nibPos;      // Positive overflow per nibble
  logic [3:0]           nibNeg;      // Negative overflow per nibble
  logic [dataWidth-1:0] paddsb;      // Saturated PADDSB result
  logic [dataWidth-1:0] shifted;
  logic [dataWidth-1:0] result;

  assign isSub   = (aluReq.op == opSub);
  assign isArith = (aluReq.op == opAdd) || isSub;

  //////////////////////////////////////////////////
  // Full-width adder and shifter
  //////////////////////////////////////////////////
  claAdder16 uAdd (
    .a      (aluReq.opA),
    .b      (aluReq.opB),
    .sub    (isSub),
    .sum    (addSum),
    .ovfl   (addOvfl),
    .posOvfl(),
    .negOvfl()
  );

  aluShifter uShift (
    .data   (aluReq.opA),
    .amount (aluReq.opB[3:0]),
    .op     (aluReq.op),
    .shifted(shifted)
  );

  //////////////////////////////////////////////////
  // PADDSB, one independent adder per nibble
  //////////////////////////////////////////////////
  for (genvar i = 0; i < 4; i++) begin : gPad
    claAdder4 uNib (
      .a      (aluReq.opA[4*i +: 4]),
      .b      (aluReq.opB[4*i +: 4]),
      .cin    (1'b0),
      .sum    (nibSum[4*i +: 4]),
      .pGroup (),
      .gGroup (),
      .posOvfl(nibPos[i]),
      .negOvfl(nibNeg[i])
    );

    assign paddsb[4*i +: 4] = nibPos[i] ? 4'h7 :   // Clamp nibble high
                              nibNeg[i] ? 4'h8 :   // Clamp nibble low
                              nibSum[4*i +: 4];
  end

  // Result select
  always_comb begin
    case (aluReq.op)
      opAdd, opSub:        result = addSum;
      opXor:               result = aluReq.opA ^ aluReq.opB;
      opPaddsb:            result = paddsb;
      opSll, opSra, opRor: result = shifted;
      default:             result = '0;   // Unused encoding
    endcase
  end

  //////////////////////////////////////////////////
  // Flags and update mask
  //////////////////////////////////////////////////
  assign aluRsp.result  = result;
  assign aluRsp.flags.z = (result == '0);
  assign aluRsp.flags.v = addOvfl;   // Only meaningful with ADD/SUB
  assign aluRsp.flags.n = result[dataWidth-1];

  assign aluRsp.flagMask.z = 1'b1;      // Every opcode writes Z
  assign aluRsp.flagMask.v = isArith;
  assign aluRsp.flagMask.n = isArith;

  // Overflow reported by the adder must show up as a clamped result
  always_comb begin : chkSat
    if (isArith && aluRsp.flags.v) begin
      assert #0 (result == 16'h7FFF || result == 16'h8000)
        else $error("aluCore overflow without saturated result %h", result);
    end
  end

endmodule

/* aluAxiRegs.sv */
`timescale 1ns/10ps

module aluAxiRegs (
  input  logic               clk,
  input  logic               rstN,
  input  aluPkg::axiLiteReqT axiReq,
  output aluPkg::axiLiteRspT axiRsp,
  output aluPkg::aluReqT     aluReq,
  input  aluPkg::aluRspT     aluRsp
);

  import aluPkg::*;

  logic [dataWidth-1:0] opA;
  logic [dataWidth-1:0] opB;
  aluOpE                op;
  logic [dataWidth-1:0] result;
  aluFlagsT             flags;
  aluFlagsT             flagsNext;    // Flags merged under the core mask
  logic                 latchPend;    // Control written last edge
  logic [dataWidth-1:0] resultView;   // Result as seen by a read
  aluFlagsT             flagsView;

  logic        wrFire;   // AW and W accepted together
  logic        rdFire;   // AR accepted
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rvalid;
  logic [1:0]  rresp;
  logic [31:0] rdata;
  logic [31:0] rdNext;
  logic [1:0]  rrNext;

  assign wrFire = axiReq.awvalid & axiReq.wvalid & ~bvalid;
  assign rdFire = axiReq.arvalid & ~rvalid;

  //////////////////////////////////////////////////
  // Write channel and operand registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      opA       <= '0;
      opB       <= '0;
      op        <= opAdd;
      latchPend <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= respOkay;
    end else begin
      latchPend <= 1'b0;   // One-shot
      if (bvalid && axiReq.bready) bvalid <= 1'b0;
      if (wrFire) begin
        bvalid <= 1'b1;
        bresp  <= respOkay;
        case (axiReq.awaddr)
          regOpA: opA <= axiReq.wdata[dataWidth-1:0];
          regOpB: opB <= axiReq.wdata[dataWidth-1:0];
          regCtrl: begin
            op        <= aluOpE'(axiReq.wdata[2:0]);
            latchPend <= 1'b1;   // Capture core output next edge
          end
          default: bresp <= respSlvErr;   // Result register is read only
        endcase
      end
    end
  end

  // Only the flags named in flagMask change
  assign flagsNext = (aluRsp.flags & aluRsp.flagMask) | (flags & ~aluRsp.flagMask);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      result <= '0;
      flags  <= '0;
    end else if (latchPend) begin
      result <= aluRsp.result;
      flags  <= flagsNext;
    end
  end

  // Forward the core output while the latch is still pending
  assign resultView = latchPend ? aluRsp.result : result;
  assign flagsView  = latchPend ? flagsNext : flags;

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////
  always_comb begin
    rdNext = '0;
    rrNext = respOkay;
    case (axiReq.araddr)
      regOpA:    rdNext[dataWidth-1:0] = opA;
      regOpB:    rdNext[dataWidth-1:0] = opB;
      regCtrl:   rdNext[2:0] = op;
      regResult: rdNext[dataWidth+2:0] = {flagsView, resultView};   // z v n at 18:16
      default:   rrNext = respSlvErr;   // Data stays zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= respOkay;
    end else begin
      if (rvalid && axiReq.rready) rvalid <= 1'b0;
      if (rdFire) begin
        rvalid <= 1'b1;
        rdata  <= rdNext;
        rresp  <= rrNext;
      end
    end
  end

  // Outputs
  assign axiRsp.awready = wrFire;
  assign axiRsp.wready  = wrFire;
  assign axiRsp.bvalid  = bvalid;
  assign axiRsp.bresp   = bresp;
  assign axiRsp.arready = ~rvalid;
  assign axiRsp.rvalid  = rvalid;
  assign axiRsp.rdata   = rdata;
  assign axiRsp.rresp   = rresp;

  assign aluReq = '{opA: opA, opB: opB, op: op};

  // Responses hold steady until the host takes them
  assert property (@(posedge clk) disable iff (!rstN)
    bvalid && !axiReq.bready |=> bvalid && $stable(bresp))
    else $error("bvalid dropped or bresp changed before bready");

  assert property (@(posedge clk) disable iff (!rstN)
    rvalid && !axiReq.rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid dropped or read data changed before rready");

endmodule

/* aluTop.sv */
`timescale 1ns/10ps

module aluTop (
  input  logic               clk,
  input  logic               rstN,
  input  aluPkg::axiLiteReqT axiReq,
  output aluPkg::axiLiteRspT axiRsp
);

  import aluPkg::*;

  aluReqT aluReq;   // Registered operands and opcode
  aluRspT aluRsp;   // Combinational core answer

  //////////////////////////////////////////////////
  // Host interface and register file
  //////////////////////////////////////////////////
  aluAxiRegs uRegs (
    .clk   (clk),
    .rstN  (rstN),
    .axiReq(axiReq),
    .axiRsp(axiRsp),
    .aluReq(aluReq),
    .aluRsp(aluRsp)
  );

  // Datapath
  aluCore uCore (
    .aluReq(aluReq),
    .aluRsp(aluRsp)
  );

endmodule

/* tbClockGen.sv */
`timescale 1ns/10ps

module tbClockGen (
  output logic clk,
  output logic rstN
);

  // 10 ns period, 100 MHz
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held low for 16 rising edges
  initial begin
    rstN = 1'b0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;   // Released on an edge like all other stimulus
  end

endmodule

/* tbAluTop.sv */
`timescale 1ns/10ps

module tbAluTop;

  import aluPkg::*;

  localparam int maxWait = 40;   // Cycles allowed for any handshake

  logic        clk;
  logic        rstN;
  axiLiteReqT  req;
  axiLiteRspT  rsp;
  logic        chkStrobe = 1'b0;   // One-cycle pulse requests a compare
  logic [31:0] expVal = '0;
  logic [31:0] actVal = '0;
  string       chkName = "";
  int          errCount = 0;
  int          okTests = 0;
  int          badTests = 0;
  logic [2:0]  refFlags = '0;      // Model copy of z v n
  logic [18:0] refResult = '0;     // Model copy of the last result word
  int unsigned seed;

  tbClockGen uClk (.clk(clk), .rstN(rstN));

  aluTop u_dut (.clk(clk), .rstN(rstN), .axiReq(req), .axiRsp(rsp));

  //////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////
  assert property (@(posedge clk) chkStrobe |-> expVal == actVal)
    else begin
      errCount++;
      $display("** Error %s: expected %h, actual %h", chkName, expVal, actVal);
    end

  assert property (@(posedge clk) disable iff (!rstN)
    rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
    else begin
      errCount++;
      $display("Write response dropped or changed before bready");
    end

  assert property (@(posedge clk) disable iff (!rstN)
    rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp))
    else begin
      errCount++;
      $display("Read response dropped or changed before rready");
    end

  // No new transfer on a channel whose response is still pending
  assert property (@(posedge clk) disable iff (!rstN)
    rsp.bvalid |-> !rsp.awready && !rsp.wready)
    else begin
      errCount++;
      $display("A second write was accepted while a write response was pending");
    end

  assert property (@(posedge clk) disable iff (!rstN) rsp.rvalid |-> !rsp.arready)
    else begin
      errCount++;
      $display("A second read was accepted while a read response was pending");
    end

  //////////////////////////////////////////////////
  // Reference model, returns {z, v, n, result}
  //////////////////////////////////////////////////
  function automatic logic [18:0] refOp(input aluOpE op, input logic [15:0] a,
                                        input logic [15:0] b, input logic [2:0] prev);
    int          exact;   // Signed result with no wrap
    int          nib;
    logic [31:0] dbl;
    logic [15:0] res;
    logic [2:0]  fl;
    fl  = prev;   // Flags not written by this opcode stay
    res = '0;
    case (op)
      opAdd, opSub: begin
        exact = (op == opSub) ? int'($signed(a)) - int'($signed(b))
                              : int'($signed(a)) + int'($signed(b));
        fl[1] = (exact > 32767) || (exact < -32768);
        res   = (exact > 32767) ? 16'h7FFF : (exact < -32768) ? 16'h8000 : exact[15:0];
        fl[0] = res[15];
      end
      opXor: res = a ^ b;
      opPaddsb: begin
        for (int i = 0; i < 4; i++) begin
          nib = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
          res[4*i +: 4] = (nib > 7) ? 4'h7 : (nib < -8) ? 4'h8 : nib[3:0];
        end
      end
      opSll: res = a << b[3:0];
      opSra: res = $signed(a) >>> b[3:0];
      opRor: begin
        dbl = {a, a} >> b[3:0];   // Low half of a doubled word is the rotation
        res = dbl[15:0];
      end
      default: res = '0;
    endcase
    fl[2] = (res == 16'h0000);
    return {fl, res};
  endfunction

  //////////////////////////////////////////////////
  // AXI tasks, drive on rising edge, sample on falling
  //////////////////////////////////////////////////
  task automatic giveUp(input string what);
    $display("Timeout while waiting for %s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data, input int hold,
                          output logic [1:0] resp);
    int t;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.wstrb   <= 4'hF;
    t = 0;
    @(negedge clk);
    while (!(rsp.awready && rsp.wready) && t < maxWait) begin
      @(negedge clk);
      t++;
    end
    if (!(rsp.awready && rsp.wready)) giveUp("the write address and data handshake");
    @(posedge clk);   // Transfer edge
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    t = 0;
    @(negedge clk);
    while (!rsp.bvalid && t < maxWait) begin
      @(negedge clk);
      t++;
    end
    if (!rsp.bvalid) giveUp("the write response");
    if (hold > 0) begin
      @(posedge clk);
      req.awvalid <= 1'b1;   // Offer another write while B is stalled
      req.wvalid  <= 1'b1;
      repeat (hold) @(posedge clk);
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
    end
    @(negedge clk);
    resp = rsp.bresp;
    @(posedge clk);
    req.bready <= 1'b1;
    @(posedge clk);
    req.bready <= 1'b0;
  endtask

  task automatic axiRead(input logic [3:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
    int t;
    @(posedge clk);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    t = 0;
    @(negedge clk);
    while (!rsp.arready && t < maxWait) begin
      @(negedge clk);
      t++;
    end
    if (!rsp.arready) giveUp("the read address handshake");
    @(posedge clk);
    req.arvalid <= 1'b0;
    t = 0;
    @(negedge clk);
    while (!rsp.rvalid && t < maxWait) begin
      @(negedge clk);
      t++;
    end
    if (!rsp.rvalid) giveUp("the read data");
    if (hold > 0) begin
      @(posedge clk);
      req.arvalid <= 1'b1;   // Same address offered again under stall
      repeat (hold) @(posedge clk);
      req.arvalid <= 1'b0;
    end
    @(negedge clk);
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk);
    req.rready <= 1'b1;
    @(posedge clk);
    req.rready <= 1'b0;
  endtask

  // Hands a compare to the checker assertion
  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    @(posedge clk);
    chkName = name;
    expVal    <= exp;
    actVal    <= act;
    chkStrobe <= 1'b1;
    @(posedge clk);
    chkStrobe <= 1'b0;
  endtask

  task automatic runOp(input aluOpE op, input logic [15:0] a, input logic [15:0] b);
    logic [18:0] exp;
    logic [31:0] data;
    logic [1:0]  resp;
    exp       = refOp(op, a, b, refFlags);
    refFlags  = exp[18:16];
    refResult = exp;
    axiWrite(regOpA, {16'h0, a}, 0, resp);
    axiWrite(regOpB, {16'h0, b}, 0, resp);
    axiWrite(regCtrl, {29'h0, op}, 0, resp);   // Starts the operation
    axiRead(regResult, 0, data, resp);
    checkValue($sformatf("%s %h %h", op.name(), a, b), {13'h0, exp}, data);
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    @(negedge clk);   // Assertion actions of the last edge have run
    if (errCount == errsBefore) begin
      okTests++;
      $display("%-12s ok", name);
    end else begin
      badTests++;
      $display("%-12s FAILED with %0d errors", name, errCount - errsBefore);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [15:0] a;
    logic [15:0] b;
    int          base;
    int          t;
    seed = $urandom(1957);
    req  = '0;
    t    = 0;
    while (!rstN && t < maxWait) begin
      @(posedge clk);
      t++;
    end
    if (!rstN) giveUp("reset release");

    base = errCount;   // Reset state
    @(negedge clk);
    checkValue("reset valids", 32'h0, {30'h0, rsp.bvalid, rsp.rvalid});
    axiRead(regResult, 0, data, resp);
    checkValue("reset result", 32'h0, data);
    reportTest("reset", base);

    base = errCount;   // Saturating add and subtract
    runOp(opAdd, 16'h7FFF, 16'h0001);
    runOp(opSub, 16'h8000, 16'h0001);
    runOp(opSub, 16'h1234, 16'h1234);
    runOp(opAdd, 16'h0001, 16'hFFFF);
    runOp(opAdd, 16'h8000, 16'h8000);
    runOp(opSub, 16'h0000, 16'h8000);
    repeat (24) runOp($urandom_range(1) ? opSub : opAdd, 16'($urandom()), 16'($urandom()));
    reportTest("addSub", base);

    base = errCount;   // Nibble adds, v and n left set by the ADD
    runOp(opAdd, 16'h8000, 16'h8000);
    runOp(opPaddsb, 16'h7777, 16'h1111);
    runOp(opPaddsb, 16'h8888, 16'h8888);
    runOp(opPaddsb, 16'h0000, 16'h0000);
    repeat (16) runOp(opPaddsb, 16'($urandom()), 16'($urandom()));
    reportTest("paddsb", base);

    base = errCount;   // Logic, shifts and rotate over every amount
    runOp(opXor, 16'hA5A5, 16'hA5A5);
    repeat (8) runOp(opXor, 16'($urandom()), 16'($urandom()));
    for (int s = 0; s < 16; s++) begin
      runOp(opSll, 16'($urandom()), {12'($urandom()), 4'(s)});
      runOp(opSra, 16'($urandom()), {12'($urandom()), 4'(s)});
      runOp(opRor, 16'($urandom()), {12'($urandom()), 4'(s)});
    end
    reportTest("shiftLogic", base);

    base = errCount;   // Error responses and readback
    a = 16'($urandom());
    b = 16'($urandom());
    axiWrite(regOpA, {16'h0, a}, 0, resp);
    axiWrite(regOpB, {16'h0, b}, 0, resp);
    axiWrite(regResult, 32'hFFFF_FFFF, 0, resp);
    checkValue("result write resp", respSlvErr, resp);
    axiWrite(4'h2, 32'hFFFF_FFFF, 0, resp);
    checkValue("unknown write resp", respSlvErr, resp);
    axiRead(regResult, 0, data, resp);
    checkValue("result unchanged", {13'h0, refResult}, data);
    axiRead(regOpA, 0, data, resp);
    checkValue("opA readback", {16'h0, a}, data);
    axiRead(regOpB, 0, data, resp);
    checkValue("opB readback", {16'h0, b}, data);
    axiRead(regCtrl, 0, data, resp);
    checkValue("ctrl readback", opRor, data);
    axiRead(4'h6, 0, data, resp);
    checkValue("unknown read resp", respSlvErr, resp);
    checkValue("unknown read data", 32'h0, data);
    reportTest("axiResp", base);

    base = errCount;   // Stalled responses
    repeat (6) begin
      a = 16'($urandom());
      axiWrite(regOpB, {16'h0, a}, 1 + $urandom_range(7), resp);
      checkValue("held bresp", respOkay, resp);
      axiRead(regOpB, 1 + $urandom_range(7), data, resp);
      checkValue("held rdata", {16'h0, a}, data);
    end
    reportTest("backPressure", base);

    $display("Summary: %0d tests ok, %0d tests failed, %0d errors", okTests, badTests, errCount);
    if (errCount == 0 && badTests == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
aluPkg.sv
claAdder4.sv
claAdder16.sv
aluShifter.sv
aluCore.sv
aluAxiRegs.sv
aluTop.sv
tbClockGen.sv
tbAluTop.sv

/* Bender.yml */
package:
  name: aluCoprocessor

sources:
  - aluPkg.sv
  - claAdder4.sv
  - claAdder16.sv
  - aluShifter.sv
  - aluCore.sv
  - aluAxiRegs.sv
  - aluTop.sv
  - target: test
    files:
      - tbClockGen.sv
      - tbAluTop.sv
